// File: compile.f
+incdir+.
isa_pkg.sv
pipe_pkg.sv
tag_reg_file.sv
issue_unit.sv
alu_unit.sv
mul_unit.sv
wb_arbiter.sv
exec_core.sv
exec_core_assertions.sv
tb_exec_core.sv

// File: Bender.yml
package:
  name: exec_core

sources:
  - target: rtl
    include_dirs:
      - .
    files:
      - isa_pkg.sv
      - pipe_pkg.sv
      - tag_reg_file.sv
      - issue_unit.sv
      - alu_unit.sv
      - mul_unit.sv
      - wb_arbiter.sv
      - exec_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - exec_core_assertions.sv
      - tb_exec_core.sv

// File: tb_exec_core.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_defines.svh"

module tb_exec_core;

    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int N_UOPS         = 400;
    localparam int TIMEOUT_CYCLES = N_UOPS * 20;
    localparam int DRAIN_CYCLES   = 16;
    localparam int N_TAGS         = 1 << `TAG_W;

    logic  clk_i;
    logic  rstn_i;
    uop_t  uop_i;
    logic  uop_valid_i;
    logic  stall_o;
    wb_t   wb_o;
    logic  wb_valid_o;

    // architectural state in program order, plus one expected record per tag.
    data_t model_regs [`N_REGS];
    wb_t   exp_wb     [N_TAGS];
    logic  exp_live   [N_TAGS];
    // newest claim per register that has not yet written back.
    logic  reg_pending [`N_REGS];
    tag_t  reg_tag     [`N_REGS];
    tag_t  next_tag;
    int    accepted_count;
    int    retired_count;
    logic  accept_next;
    logic  preloading;
    wb_t   preload_wb;

    exec_core DUT (
        .clk_i(clk_i), .rstn_i(rstn_i), .uop_i(uop_i), .uop_valid_i(uop_valid_i),
        .stall_o(stall_o), .wb_o(wb_o), .wb_valid_o(wb_valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    task automatic fail_run();
        $display("SIMULATION FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic report_error(input string msg);
        $display("ERROR: %s", msg);
        fail_run();
    endtask

    task automatic check_equal(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
            fail_run();
        end
    endtask

    // mostly r0 to r7, so that dependences are frequent.
    function automatic reg_addr_t pick_reg();
        if (($urandom % 8) == 0) begin
            return reg_addr_t'($urandom % `N_REGS);
        end
        return reg_addr_t'($urandom % 8);
    endfunction

    function automatic uop_t random_uop();
        uop_t u;
        u.op   = op_t'($urandom % 7);
        u.dst  = pick_reg();
        u.src1 = pick_reg();
        u.src2 = pick_reg();
        return u;
    endfunction

    function automatic data_t expected_result(input op_t op, input data_t a, input data_t b);
        logic [63:0] product;
        product = {32'b0, a} * {32'b0, b};
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SLL:  return a << b[4:0];
            OP_MUL:  return product[31:0];
            default: return '0;
        endcase
    endfunction

    task automatic record_acceptance();
        wb_t exp;
        exp.tag  = next_tag;
        exp.dst  = uop_i.dst;
        exp.data = expected_result(uop_i.op, model_regs[uop_i.src1], model_regs[uop_i.src2]);
        if (exp_live[next_tag]) begin
            report_error($sformatf("tag %0d handed out again while outstanding", next_tag));
        end else begin
            exp_wb[next_tag]   = exp;
            exp_live[next_tag] = 1'b1;
            if (uop_i.dst != '0) begin
                model_regs[uop_i.dst]  = exp.data;
                reg_pending[uop_i.dst] = 1'b1;
                reg_tag[uop_i.dst]     = next_tag;
            end
            next_tag       = next_tag + 1'b1;
            accepted_count = accepted_count + 1;
        end
    endtask

    // results are matched by tag, so retirement order does not matter.
    task automatic check_writeback();
        tag_t  t;
        string name;
        t = wb_o.tag;
        if (exp_live[t] !== 1'b1) begin
            report_error($sformatf("writeback for tag %0d with no outstanding record", t));
        end else begin
            name = $sformatf("writeback tag %0d", t);
            check_equal({name, " dst"}, 64'(exp_wb[t].dst), 64'(wb_o.dst));
            check_equal({name, " data"}, 64'(exp_wb[t].data), 64'(wb_o.data));
            if (reg_pending[wb_o.dst] && reg_tag[wb_o.dst] == t) begin
                reg_pending[wb_o.dst] = 1'b0;
            end
            exp_live[t]   = 1'b0;
            retired_count = retired_count + 1;
        end
    endtask

    // a micro-operation whose source still waits for its producer is held back.
    task automatic check_source_stall();
        if (uop_valid_i && (reg_pending[uop_i.src1] || reg_pending[uop_i.src2])) begin
            check_equal("stall on pending source", 64'(1'b1), 64'(stall_o));
        end
    endtask

    // the instruction set has no immediates, so the register file is seeded
    // through its own writeback port under the reset tag.
    task automatic preload_registers();
        data_t value;
        @(negedge clk_i);
        force DUT.wb_valid_o = 1'b1;
        force DUT.wb_o       = preload_wb;
        for (int r = 1; r < `N_REGS; r++) begin
            value         = $urandom;
            preload_wb    = '{tag: '0, dst: reg_addr_t'(r), data: value};
            model_regs[r] = value;
            @(negedge clk_i);
        end
        release DUT.wb_valid_o;
        release DUT.wb_o;
        @(posedge clk_i);
        preloading = 1'b0;
    endtask

    // a presented micro-operation is held until it is accepted.
    task automatic drive_program();
        int sent;
        sent = 0;
        while (accepted_count < N_UOPS) begin
            @(posedge clk_i);
            if (!uop_valid_i || accept_next) begin
                if (sent < N_UOPS && ($urandom % 8) != 0) begin
                    uop_i       <= random_uop();
                    uop_valid_i <= 1'b1;
                    sent++;
                end else begin
                    uop_valid_i <= 1'b0;
                end
            end
        end
    endtask

    task automatic report_verdict();
        int leftover;
        leftover = 0;
        for (int t = 0; t < N_TAGS; t++) begin
            if (exp_live[t]) begin
                leftover++;
            end
        end
        if (leftover != 0 || retired_count != N_UOPS) begin
            report_error($sformatf("%0d tags never retired, %0d of %0d writebacks seen",
                                   leftover, retired_count, N_UOPS));
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    endtask

    // values here hold until the next rising edge, where they take effect.
    always @(negedge clk_i) begin
        if (rstn_i && !preloading) begin
            if (wb_valid_o) begin
                check_writeback();
            end
            check_source_stall();
            accept_next = uop_valid_i && !stall_o;
            if (accept_next) begin
                record_acceptance();
            end
        end else begin
            accept_next = 1'b0;
        end
    end

    initial begin
        wait (DUT.u_assertions.assert_failed === 1'b1);
        report_error("a protocol assertion bound into exec_core failed");
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk_i);
        report_error($sformatf("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES));
    end

    initial begin
        void'($urandom(32'h7e67_78a5));
        rstn_i         = 1'b0;
        uop_i          = '0;
        uop_valid_i    = 1'b0;
        preloading     = 1'b1;
        accept_next    = 1'b0;
        preload_wb     = '0;
        next_tag       = '0;
        accepted_count = 0;
        retired_count  = 0;
        for (int r = 0; r < `N_REGS; r++) begin
            model_regs[r]  = '0;
            reg_pending[r] = 1'b0;
            reg_tag[r]     = '0;
        end
        for (int t = 0; t < N_TAGS; t++) begin
            exp_live[t] = 1'b0;
        end
        repeat (4) @(posedge clk_i);
        rstn_i <= 1'b1;
        preload_registers();
        drive_program();
        repeat (DRAIN_CYCLES) @(posedge clk_i);
        report_verdict();
    end

endmodule

`default_nettype wire

// File: exec_core_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module exec_core_assertions (
    input wire                clk_i,
    input wire                rstn_i,
    input wire                stall_i,
    input wire                wb_valid_i,
    input wire                alu_grant_i,
    input wire                mul_grant_i,
    input wire                alu_res_valid_i,
    input wire                mul_res_valid_i,
    input wire pipe_pkg::wb_t alu_res_i,
    input wire pipe_pkg::wb_t mul_res_i
);

    logic assert_failed = 1'b0;

    one_grant: assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(alu_grant_i && mul_grant_i))
        else begin
            $error("alu and multiplier granted in the same cycle");
            assert_failed = 1'b1;
        end

    // first reset edge only loads the registers.
    quiet_in_reset: assert property (@(posedge clk_i)
        !rstn_i ##1 !rstn_i |-> !wb_valid_i && !stall_i)
        else begin
            $error("writeback or stall active during reset");
            assert_failed = 1'b1;
        end

    alu_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        alu_res_valid_i && !alu_grant_i |=> alu_res_valid_i && $stable(alu_res_i))
        else begin
            $error("alu result changed before its grant");
            assert_failed = 1'b1;
        end

    mul_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        mul_res_valid_i && !mul_grant_i |=> mul_res_valid_i && $stable(mul_res_i))
        else begin
            $error("multiplier result changed before its grant");
            assert_failed = 1'b1;
        end

endmodule

bind exec_core exec_core_assertions u_assertions (
    .clk_i(clk_i), .rstn_i(rstn_i), .stall_i(stall_o), .wb_valid_i(wb_valid_o),
    .alu_grant_i(alu_grant), .mul_grant_i(mul_grant),
    .alu_res_valid_i(alu_res_valid), .mul_res_valid_i(mul_res_valid),
    .alu_res_i(alu_res), .mul_res_i(mul_res)
);

`default_nettype wire

// File: exec_core.sv
`timescale 1ns/100ps
`default_nettype none

module exec_core (
    input  wire                clk_i,
    input  wire                rstn_i,
    input  wire isa_pkg::uop_t uop_i,
    input  wire                uop_valid_i,
    output logic               stall_o,
    output pipe_pkg::wb_t      wb_o,
    output logic               wb_valid_o
);

    import isa_pkg::*;
    import pipe_pkg::*;

    reg_addr_t rd_addr1, rd_addr2, tag_addr;
    data_t     rd_data1, rd_data2;
    logic      rd_ready1, rd_ready2;
    tag_t      tag;
    logic      tag_valid;

    exec_req_t req;
    logic      alu_req_valid, mul_req_valid;
    logic      alu_busy, mul_busy;

    wb_t       alu_res, mul_res;
    logic      alu_res_valid, mul_res_valid;
    logic      alu_grant, mul_grant;

    issue_unit u_issue (
        .clk_i(clk_i), .rstn_i(rstn_i), .uop_i(uop_i), .uop_valid_i(uop_valid_i),
        .rd_data1_i(rd_data1), .rd_data2_i(rd_data2),
        .rd_ready1_i(rd_ready1), .rd_ready2_i(rd_ready2),
        .alu_busy_i(alu_busy), .mul_busy_i(mul_busy), .stall_o(stall_o),
        .rd_addr1_o(rd_addr1), .rd_addr2_o(rd_addr2), .tag_addr_o(tag_addr),
        .tag_o(tag), .tag_valid_o(tag_valid), .req_o(req),
        .alu_req_valid_o(alu_req_valid), .mul_req_valid_o(mul_req_valid)
    );

    tag_reg_file u_regs (
        .clk_i(clk_i), .rstn_i(rstn_i), .rd_addr1_i(rd_addr1), .rd_addr2_i(rd_addr2),
        .tag_addr_i(tag_addr), .tag_i(tag), .tag_valid_i(tag_valid),
        .wb_i(wb_o), .wb_valid_i(wb_valid_o),
        .rd_data1_o(rd_data1), .rd_data2_o(rd_data2),
        .rd_ready1_o(rd_ready1), .rd_ready2_o(rd_ready2)
    );

    alu_unit u_alu (
        .clk_i(clk_i), .rstn_i(rstn_i), .req_i(req), .req_valid_i(alu_req_valid),
        .grant_i(alu_grant), .busy_o(alu_busy), .res_o(alu_res), .res_valid_o(alu_res_valid)
    );

    mul_unit u_mul (
        .clk_i(clk_i), .rstn_i(rstn_i), .req_i(req), .req_valid_i(mul_req_valid),
        .grant_i(mul_grant), .busy_o(mul_busy), .res_o(mul_res), .res_valid_o(mul_res_valid)
    );

    wb_arbiter u_arb (
        .clk_i(clk_i), .rstn_i(rstn_i),
        .alu_res_i(alu_res), .alu_res_valid_i(alu_res_valid),
        .mul_res_i(mul_res), .mul_res_valid_i(mul_res_valid),
        .alu_grant_o(alu_grant), .mul_grant_o(mul_grant),
        .wb_o(wb_o), .wb_valid_o(wb_valid_o)
    );

endmodule

`default_nettype wire

// File: wb_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module wb_arbiter (
    input  wire                clk_i,
    input  wire                rstn_i,
    input  wire pipe_pkg::wb_t alu_res_i,
    input  wire                alu_res_valid_i,
    input  wire pipe_pkg::wb_t mul_res_i,
    input  wire                mul_res_valid_i,
    output logic               alu_grant_o,
    output logic               mul_grant_o,
    output pipe_pkg::wb_t      wb_o,
    output logic               wb_valid_o
);

    // set when the multiplier had the last grant.
    logic last_mul_q;

    // on a tie the unit not served last wins.
    assign alu_grant_o = alu_res_valid_i && (!mul_res_valid_i || last_mul_q);
    assign mul_grant_o = mul_res_valid_i && (!alu_res_valid_i || !last_mul_q);

    assign wb_o       = mul_grant_o ? mul_res_i : alu_res_i;
    assign wb_valid_o = alu_res_valid_i || mul_res_valid_i;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            last_mul_q <= 1'b0;
        end else if (alu_grant_o) begin
            last_mul_q <= 1'b0;
        end else if (mul_grant_o) begin
            last_mul_q <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: mul_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_defines.svh"

module mul_unit (
    input  wire                      clk_i,
    input  wire                      rstn_i,
    input  wire pipe_pkg::exec_req_t req_i,
    input  wire                      req_valid_i,
    input  wire                      grant_i,
    output logic                     busy_o,
    output pipe_pkg::wb_t            res_o,
    output logic                     res_valid_o
);

    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int LAST = `MUL_STAGES - 1;

    logic [`MUL_STAGES-1:0] valid_q;
    tag_t                   tag_q  [`MUL_STAGES];
    reg_addr_t              dst_q  [`MUL_STAGES];
    data_t                  prod_q [`MUL_STAGES];
    data_t                  a_q;
    logic [15:0]            bhi_q;

    logic                   advance;
    data_t                  hi_part;

    // the last stage doubles as the result buffer.
    assign advance = !(valid_q[LAST] && !grant_i);
    assign busy_o  = !advance;

    // the product of a with the upper half of b keeps only the low word.
    assign hi_part = a_q * {bhi_q, 16'b0};

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            valid_q <= '0;
        end else if (advance) begin
            valid_q <= {valid_q[LAST-1:0], req_valid_i};
        end
    end

    always_ff @(posedge clk_i) begin
        if (advance) begin
            // stage 0 multiplies by the lower half of b.
            tag_q[0]  <= req_i.tag;
            dst_q[0]  <= req_i.dst;
            prod_q[0] <= req_i.a * {16'b0, req_i.b[15:0]};
            a_q       <= req_i.a;
            bhi_q     <= req_i.b[31:16];

            tag_q[1]  <= tag_q[0];
            dst_q[1]  <= dst_q[0];
            prod_q[1] <= prod_q[0] + hi_part;

            for (int k = 2; k < `MUL_STAGES; k++) begin
                tag_q[k]  <= tag_q[k-1];
                dst_q[k]  <= dst_q[k-1];
                prod_q[k] <= prod_q[k-1];
            end
        end
    end

    assign res_o       = '{tag: tag_q[LAST], dst: dst_q[LAST], data: prod_q[LAST]};
    assign res_valid_o = valid_q[LAST];

endmodule

`default_nettype wire

// File: alu_unit.sv
`timescale 1ns/100ps
`default_nettype none

module alu_unit (
    input  wire                      clk_i,
    input  wire                      rstn_i,
    input  wire pipe_pkg::exec_req_t req_i,
    input  wire                      req_valid_i,
    input  wire                      grant_i,
    output logic                     busy_o,
    output pipe_pkg::wb_t            res_o,
    output logic                     res_valid_o
);

    import isa_pkg::*;
    import pipe_pkg::*;

    wb_t   res_q;
    logic  res_valid_q;
    data_t result;
    logic  take;

    always_comb begin
        case (req_i.op)
            OP_ADD:  result = req_i.a + req_i.b;
            OP_SUB:  result = req_i.a - req_i.b;
            OP_AND:  result = req_i.a & req_i.b;
            OP_OR:   result = req_i.a | req_i.b;
            OP_XOR:  result = req_i.a ^ req_i.b;
            OP_SLL:  result = req_i.a << req_i.b[4:0];
            default: result = '0;
        endcase
    end

    // a buffer granted this cycle frees up for the next request.
    assign busy_o = res_valid_q && !grant_i;
    assign take   = req_valid_i && !busy_o;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            res_valid_q <= 1'b0;
        end else if (take) begin
            res_valid_q <= 1'b1;
        end else if (grant_i) begin
            res_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            res_q <= '{tag: req_i.tag, dst: req_i.dst, data: result};
        end
    end

    assign res_o       = res_q;
    assign res_valid_o = res_valid_q;

endmodule

`default_nettype wire

// File: issue_unit.sv
`timescale 1ns/100ps
`default_nettype none

module issue_unit (
    input  wire                 clk_i,
    input  wire                 rstn_i,
    input  wire isa_pkg::uop_t  uop_i,
    input  wire                 uop_valid_i,
    input  wire isa_pkg::data_t rd_data1_i,
    input  wire isa_pkg::data_t rd_data2_i,
    input  wire                 rd_ready1_i,
    input  wire                 rd_ready2_i,
    input  wire                 alu_busy_i,
    input  wire                 mul_busy_i,
    output logic                stall_o,
    output isa_pkg::reg_addr_t  rd_addr1_o,
    output isa_pkg::reg_addr_t  rd_addr2_o,
    output isa_pkg::reg_addr_t  tag_addr_o,
    output pipe_pkg::tag_t      tag_o,
    output logic                tag_valid_o,
    output pipe_pkg::exec_req_t req_o,
    output logic                alu_req_valid_o,
    output logic                mul_req_valid_o
);

    import isa_pkg::*;
    import pipe_pkg::*;

    exec_req_t req_q;
    logic      full_q;
    logic      is_mul_q;
    tag_t      tag_q;

    logic      target_busy;
    logic      fire;
    logic      accept;

    // operand reads go straight from the incoming micro-operation.
    assign rd_addr1_o = uop_i.src1;
    assign rd_addr2_o = uop_i.src2;

    assign target_busy = is_mul_q ? mul_busy_i : alu_busy_i;
    assign fire        = full_q && !target_busy;

    // a pending source or a blocked issue register holds the front end.
    assign stall_o = (full_q && target_busy) || !rd_ready1_i || !rd_ready2_i;
    assign accept  = uop_valid_i && !stall_o;

    // claim the destination under the new tag unless it is r0.
    assign tag_addr_o  = uop_i.dst;
    assign tag_o       = tag_q;
    assign tag_valid_o = accept && (uop_i.dst != '0);

    assign req_o           = req_q;
    assign alu_req_valid_o = full_q && !is_mul_q;
    assign mul_req_valid_o = full_q && is_mul_q;

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            full_q   <= 1'b0;
            is_mul_q <= 1'b0;
            tag_q    <= '0;
        end else begin
            if (accept) begin
                full_q   <= 1'b1;
                is_mul_q <= (uop_i.op == OP_MUL);
                tag_q    <= tag_q + 1'b1;
            end else if (fire) begin
                full_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            req_q.op  <= uop_i.op;
            req_q.tag <= tag_q;
            req_q.dst <= uop_i.dst;
            req_q.a   <= rd_data1_i;
            req_q.b   <= rd_data2_i;
        end
    end

endmodule

`default_nettype wire

// File: tag_reg_file.sv
`timescale 1ns/100ps
`default_nettype none

`include "core_defines.svh"

module tag_reg_file (
    input  wire                 clk_i,
    input  wire                 rstn_i,
    input  wire isa_pkg::reg_addr_t rd_addr1_i,
    input  wire isa_pkg::reg_addr_t rd_addr2_i,
    input  wire isa_pkg::reg_addr_t tag_addr_i,
    input  wire pipe_pkg::tag_t tag_i,
    input  wire                 tag_valid_i,
    input  wire pipe_pkg::wb_t  wb_i,
    input  wire                 wb_valid_i,
    output isa_pkg::data_t      rd_data1_o,
    output isa_pkg::data_t      rd_data2_o,
    output logic                rd_ready1_o,
    output logic                rd_ready2_o
);

    import isa_pkg::*;
    import pipe_pkg::*;

    data_t              data_q [`N_REGS];
    tag_t               tag_q  [`N_REGS];
    logic [`N_REGS-1:0] valid_q;

    // register 0 is never written, so it keeps its reset value of zero and valid.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < `N_REGS; i++) begin
                data_q[i] <= '0;
                tag_q[i]  <= '0;
            end
            valid_q <= '1;
        end else begin
            for (int i = 1; i < `N_REGS; i++) begin
                // an older result never replaces the value of a newer claim.
                if (wb_valid_i && wb_i.dst == reg_addr_t'(i) && wb_i.tag == tag_q[i]) begin
                    data_q[i] <= wb_i.data;
                end

                // a new claim wins over a writeback in the same cycle.
                if (tag_valid_i && tag_addr_i == reg_addr_t'(i)) begin
                    tag_q[i]   <= tag_i;
                    valid_q[i] <= 1'b0;
                end else if (wb_valid_i && wb_i.dst == reg_addr_t'(i)
                             && wb_i.tag == tag_q[i]) begin
                    valid_q[i] <= 1'b1;
                end
            end
        end
    end

    // combinational read ports.
    assign rd_data1_o  = data_q[rd_addr1_i];
    assign rd_ready1_o = valid_q[rd_addr1_i];
    assign rd_data2_o  = data_q[rd_addr2_i];
    assign rd_ready2_o = valid_q[rd_addr2_i];

endmodule

`default_nettype wire

// File: pipe_pkg.sv
`default_nettype none

`include "core_defines.svh"

package pipe_pkg;

    typedef logic [`TAG_W-1:0] tag_t;

    // request from the issue register to an execution unit.
    typedef struct packed {
        isa_pkg::op_t      op;
        tag_t              tag;
        isa_pkg::reg_addr_t dst;
        isa_pkg::data_t    a;
        isa_pkg::data_t    b;
    } exec_req_t;

    // result record on its way to the register file.
    typedef struct packed {
        tag_t               tag;
        isa_pkg::reg_addr_t dst;
        isa_pkg::data_t     data;
    } wb_t;

endpackage

`default_nettype wire

// File: isa_pkg.sv
`default_nettype none

`include "core_defines.svh"

package isa_pkg;

    typedef logic [`DATA_W-1:0]     data_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [2:0]             op_t;

    // operation codes.
    localparam op_t OP_ADD = 3'd0;
    localparam op_t OP_SUB = 3'd1;
    localparam op_t OP_AND = 3'd2;
    localparam op_t OP_OR  = 3'd3;
    localparam op_t OP_XOR = 3'd4;
    localparam op_t OP_SLL = 3'd5;
    localparam op_t OP_MUL = 3'd6;

    // micro-operation as it arrives in program order.
    typedef struct packed {
        op_t       op;
        reg_addr_t dst;
        reg_addr_t src1;
        reg_addr_t src2;
    } uop_t;

endpackage

`default_nettype wire

// File: core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// architectural widths.
`define DATA_W      32
`define REG_ADDR_W  5
`define N_REGS      32

// the tag space covers every micro-operation in flight.
`define TAG_W       4

// multiplier latency in cycles.
`define MUL_STAGES  3

`endif
